// ==== common/fg_pkg.sv ====
package fg_pkg;

	// channel count
	localparam int num_channels = 4;
	// width of a channel index in a command word
	localparam int chan_bits = 2;
	// one pattern byte per lane per clock
	localparam int data_width = 8;
	// 2048-entry pattern ram per channel
	localparam int addr_width = 11;
	localparam int ram_depth = 1 << addr_width;

	// payload is sized by its widest view, the two bounds addresses
	localparam int payload_width = 2 * addr_width;
	// filler in front of the write view
	localparam int write_pad_bits = payload_width - addr_width - data_width;
	// filler in front of the enable mask
	localparam int enable_pad_bits = payload_width - num_channels;

	typedef logic [chan_bits-1:0] chan_idx_t;
	typedef logic [data_width-1:0] data_t;
	typedef logic [addr_width-1:0] addr_t;

	// host command opcodes
	typedef enum logic [1:0] {
		op_write = 2'd0,
		op_bounds = 2'd1,
		op_sync = 2'd2,
		op_enable = 2'd3
	} opcode_t;

	// one byte into one channel's ram
	typedef struct packed {
		logic [write_pad_bits-1:0] pad;
		addr_t address;
		data_t data;
	} write_view_t;

	// loop window, both ends inclusive
	typedef struct packed {
		addr_t start_address;
		addr_t end_address;
	} bounds_view_t;

	// lane enable mask, one bit per channel
	typedef struct packed {
		logic [enable_pad_bits-1:0] pad;
		logic [num_channels-1:0] mask;
	} enable_view_t;

	// same payload bits, read according to the opcode
	typedef union packed {
		write_view_t write;
		bounds_view_t bounds;
		enable_view_t enable;
	} cmd_payload_u;

	// word on the top-level command port
	typedef struct packed {
		opcode_t opcode;
		chan_idx_t channel;
		cmd_payload_u payload;
	} cmd_word_t;

	// combined output word, lane n is channel n
	typedef data_t [num_channels-1:0] lanes_t;

endpackage

// ==== common/pattern_if.sv ====
// per-channel config path from the command decoder
interface pattern_if import fg_pkg::*; ();

	// one-cycle ram write strobe
	logic write_enable;
	// ram write address and byte, valid with the strobe
	addr_t write_address;
	data_t write_data;

	// last programmed loop window, held as levels
	addr_t start_address;
	addr_t end_address;

	// one-cycle restart pulse, same on every channel
	logic sync;

	// decoder side drives everything
	modport decoder (
		output write_enable,
		output write_address,
		output write_data,
		output start_address,
		output end_address,
		output sync
	);

	// channel side only listens
	modport channel (
		input write_enable,
		input write_address,
		input write_data,
		input start_address,
		input end_address,
		input sync
	);

endinterface

// ==== dv/pattern_generator_asserts.sv ====
module pattern_generator_asserts import fg_pkg::*; (
	input logic clock,
	input logic rst,
	input logic sync,
	input addr_t start_address,
	input addr_t read_address,
	input addr_t active_start,
	input addr_t active_end,
	input logic write_enable,
	input addr_t write_address
);
	timeunit 1ns;
	timeprecision 100ps;

	// failed assertions, per property
	int window_fails = 0;
	int sync_fails = 0;
	int write_fails = 0;
	int failures;
	// first sync seen since reset
	logic synced;

	assign failures = window_fails + sync_fails + write_fails;

	always_ff @(posedge clock) begin
		if (rst) begin
			synced <= 1'b0;
		end else if (sync) begin
			synced <= 1'b1;
		end
	end

	// address never leaves the running window
	window_check: assert property (@(posedge clock) disable iff (rst)
		synced |-> (read_address >= active_start && read_address <= active_end))
		else begin
			window_fails++;
			$error("read address %0d outside window %0d..%0d", read_address,
				active_start, active_end);
		end

	// restart lands on the programmed start one edge later
	sync_check: assert property (@(posedge clock) disable iff (rst)
		sync |=> (read_address == $past(start_address)))
		else begin
			sync_fails++;
			$error("read address %0d not at start after sync", read_address);
		end

	// ram writes only to a known address inside the ram
	write_check: assert property (@(posedge clock) disable iff (rst)
		write_enable |-> (!$isunknown(write_address) && int'(write_address) < ram_depth))
		else begin
			write_fails++;
			$error("ram write to bad address %h", write_address);
		end

endmodule

// ==== dv/pattern_generator_tb.sv ====
module pattern_generator_tb import fg_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int clock_period = 8;
	localparam int reset_cycles = 5;
	// bytes loaded per channel, every window stays below this
	localparam int fill_depth = 64;
	localparam int frame_timeout = 200;

	// one table row, a command and the cycles watched after it
	typedef struct {
		logic after_frame;
		cmd_word_t cmd;
		int observe;
	} row_t;

	logic clock;
	logic rst;
	logic cmd_valid;
	cmd_word_t cmd;
	lanes_t data_out;
	logic frame_start;

	row_t table_rows [$];
	logic [31:0] rng_state;
	int lane_errors;
	int flag_errors;
	int wait_errors;
	int assert_failures;

	// reference model: shadow rams and programmed windows
	data_t shadow [num_channels][ram_depth];
	addr_t prog_start [num_channels];
	addr_t prog_end [num_channels];
	logic [num_channels-1:0] prog_mask;
	// index k holds the state programmed k edges ago
	logic sync_hist [4];
	addr_t start_hist [4][num_channels];
	addr_t end_hist [4][num_channels];
	logic [num_channels-1:0] mask_hist [3];
	// address of the byte on each lane right now
	addr_t out_addr [num_channels];
	addr_t act_end [num_channels];
	logic [num_channels-1:0] out_valid;
	logic exp_frame;

	pattern_generator dut (
		.clock(clock),
		.rst(rst),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.data_out(data_out),
		.frame_start(frame_start)
	);

	bind pattern_channel pattern_generator_asserts u_asserts (
		.clock(clock),
		.rst(rst),
		.sync(cfg.sync),
		.start_address(cfg.start_address),
		.read_address(read_address),
		.active_start(active_start),
		.active_end(active_end),
		.write_enable(cfg.write_enable),
		.write_address(cfg.write_address)
	);

	initial begin
		clock = 1'b0;
		forever #(clock_period / 2) clock = ~clock;
	end

	// xorshift32
	function automatic data_t next_random();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return data_t'(rng_state);
	endfunction

	task automatic reset_model();
		int ch;
		int k;
		for (ch = 0; ch < num_channels; ch++) begin
			prog_start[ch] = '0;
			prog_end[ch] = '1;
			out_addr[ch] = '0;
			act_end[ch] = '1;
		end
		for (k = 0; k < 4; k++) begin
			start_hist[k] = prog_start;
			end_hist[k] = prog_end;
		end
		sync_hist = '{default: 1'b0};
		mask_hist = '{default: '0};
		prog_mask = '0;
		out_valid = '0;
		exp_frame = 1'b0;
	endtask

	// one rising edge seen from the host side and from the output side
	task automatic model_edge(input logic valid, input cmd_word_t c);
		int ch;
		int k;
		logic do_sync;
		do_sync = 1'b0;
		if (valid) begin
			case (c.opcode)
				op_write: shadow[c.channel][c.payload.write.address] = c.payload.write.data;
				op_bounds: begin
					prog_start[c.channel] = c.payload.bounds.start_address;
					prog_end[c.channel] = c.payload.bounds.end_address;
				end
				op_sync: do_sync = 1'b1;
				op_enable: prog_mask = c.payload.enable.mask;
			endcase
		end
		for (k = 3; k > 0; k--) begin
			sync_hist[k] = sync_hist[k-1];
			start_hist[k] = start_hist[k-1];
			end_hist[k] = end_hist[k-1];
		end
		sync_hist[0] = do_sync;
		start_hist[0] = prog_start;
		end_hist[0] = prog_end;
		// mask reaches the output 2 edges after its command
		mask_hist[2] = mask_hist[1];
		mask_hist[1] = mask_hist[0];
		mask_hist[0] = prog_mask;
		// lanes restart 3 edges after a sync, or right after their end byte
		exp_frame = 1'b0;
		for (ch = 0; ch < num_channels; ch++) begin
			if (sync_hist[3] || (out_valid[ch] && out_addr[ch] == act_end[ch])) begin
				out_addr[ch] = start_hist[3][ch];
				act_end[ch] = end_hist[3][ch];
				out_valid[ch] = 1'b1;
				if (ch == 0) begin
					exp_frame = 1'b1;
				end
			end else begin
				out_addr[ch] = out_addr[ch] + addr_t'(1);
			end
		end
	endtask

	function automatic lanes_t expected_lanes();
		lanes_t lanes;
		int ch;
		lanes = '0;
		for (ch = 0; ch < num_channels; ch++) begin
			if (mask_hist[2][ch]) begin
				lanes[ch] = shadow[ch][out_addr[ch]];
			end
		end
		return lanes;
	endfunction

	task automatic check_lanes(input lanes_t expected, input lanes_t actual);
		if (actual !== expected) begin
			lane_errors++;
			$display("FAILED at %0t: data_out expected %h, got %h", $time, expected, actual);
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			flag_errors++;
			$display("FAILED at %0t: %s expected %b, got %b", $time, name, expected, actual);
		end
	endtask

	// outputs are stable at the falling edge, next inputs go out there too
	task automatic run_cycle(input logic valid, input cmd_word_t c);
		@(negedge clock);
		check_lanes(expected_lanes(), data_out);
		check_flag("frame_start", exp_frame, frame_start);
		cmd_valid = valid;
		cmd = c;
		model_edge(valid, c);
	endtask

	task automatic wait_frame(input int limit);
		int waited;
		waited = 0;
		while (frame_start !== 1'b1 && waited < limit) begin
			run_cycle(1'b0, '0);
			waited++;
		end
		if (frame_start !== 1'b1) begin
			wait_errors++;
			$display("no frame_start pulse seen within %0d cycles", limit);
		end
	endtask

	task automatic load_patterns();
		cmd_word_t w;
		int ch;
		int a;
		for (ch = 0; ch < num_channels; ch++) begin
			for (a = 0; a < fill_depth; a++) begin
				w = '0;
				w.opcode = op_write;
				w.channel = chan_idx_t'(ch);
				w.payload.write.address = addr_t'(a);
				w.payload.write.data = next_random();
				run_cycle(1'b1, w);
			end
		end
	endtask

	task automatic add_row(input opcode_t op, input chan_idx_t ch,
			input logic [payload_width-1:0] bits, input logic after_frame, input int observe);
		row_t r;
		r.after_frame = after_frame;
		r.cmd.opcode = op;
		r.cmd.channel = ch;
		r.cmd.payload = bits;
		r.observe = observe;
		table_rows.push_back(r);
	endtask

	task automatic build_table();
		// windows of different lengths
		add_row(op_bounds, 2'd0, {addr_t'(4), addr_t'(19)}, 1'b0, 0);
		add_row(op_bounds, 2'd1, {addr_t'(10), addr_t'(40)}, 1'b0, 0);
		add_row(op_bounds, 2'd2, {addr_t'(0), addr_t'(6)}, 1'b0, 0);
		add_row(op_bounds, 2'd3, {addr_t'(50), addr_t'(63)}, 1'b0, 0);
		// sync, then all lanes open on the first synced byte
		add_row(op_sync, 2'd3, '0, 1'b0, 0);
		add_row(op_enable, 2'd2, payload_width'(4'b1111), 1'b0, 60);
		// new windows written in mid-pass
		add_row(op_bounds, 2'd0, {addr_t'(30), addr_t'(37)}, 1'b1, 40);
		add_row(op_bounds, 2'd1, {addr_t'(0), addr_t'(3)}, 1'b0, 10);
		// lanes 0 and 2 off while the marker keeps going
		add_row(op_enable, 2'd1, payload_width'(4'b1010), 1'b1, 30);
		add_row(op_enable, 2'd0, payload_width'(4'b1111), 1'b0, 5);
		// restart everything in mid-stream
		add_row(op_sync, 2'd1, '0, 1'b0, 40);
		add_row(op_enable, 2'd0, '0, 1'b0, 10);
	endtask

	initial begin
		rst = 1'b1;
		cmd_valid = 1'b0;
		cmd = '0;
		rng_state = 32'd38;
		lane_errors = 0;
		flag_errors = 0;
		wait_errors = 0;
		reset_model();
		build_table();
		repeat (reset_cycles) @(posedge clock);
		@(negedge clock);
		rst = 1'b0;
		model_edge(1'b0, '0);
		// idle after reset, lanes and marker stay low
		repeat (12) run_cycle(1'b0, '0);
		load_patterns();
		foreach (table_rows[i]) begin
			if (table_rows[i].after_frame) begin
				wait_frame(frame_timeout);
			end
			run_cycle(1'b1, table_rows[i].cmd);
			repeat (table_rows[i].observe) run_cycle(1'b0, '0);
		end
		wait_frame(frame_timeout);
		repeat (4) run_cycle(1'b0, '0);
		assert_failures = dut.g_chan[0].u_channel.u_asserts.failures
			+ dut.g_chan[1].u_channel.u_asserts.failures
			+ dut.g_chan[2].u_channel.u_asserts.failures
			+ dut.g_chan[3].u_channel.u_asserts.failures;
		$display("errors: data_out %0d, frame_start %0d, timeouts %0d, assertions %0d",
			lane_errors, flag_errors, wait_errors, assert_failures);
		if (lane_errors + flag_errors + wait_errors + assert_failures == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// ==== flist.f ====
common/fg_pkg.sv
common/pattern_if.sv
hw/command_decoder.sv
pattern_channel/pattern_ram.sv
pattern_channel/pattern_channel.sv
hw/lane_combiner.sv
hw/pattern_generator.sv
dv/pattern_generator_asserts.sv
dv/pattern_generator_tb.sv

// ==== hw/command_decoder.sv ====
module command_decoder import fg_pkg::*; (
	input logic clock,
	input logic rst,
	input logic cmd_valid,
	input cmd_word_t cmd,
	pattern_if.decoder chans [num_channels],
	output logic [num_channels-1:0] enables
);

	// opcode strobes, already qualified by cmd_valid
	logic is_write;
	logic is_bounds;
	logic is_sync;
	logic is_enable;

	// opcode decode
	always_comb begin
		is_write = 1'b0;
		is_bounds = 1'b0;
		is_sync = 1'b0;
		is_enable = 1'b0;
		if (cmd_valid) begin
			case (cmd.opcode)
				op_write: is_write = 1'b1;
				op_bounds: is_bounds = 1'b1;
				op_sync: is_sync = 1'b1;
				op_enable: is_enable = 1'b1;
			endcase
		end
	end

	for (genvar ch = 0; ch < num_channels; ch++) begin : g_chan
		// command addresses this channel
		logic hit;

		assign hit = (cmd.channel == chan_idx_t'(ch));

		// strobes and window levels
		always_ff @(posedge clock) begin
			if (rst) begin
				chans[ch].write_enable <= 1'b0;
				chans[ch].sync <= 1'b0;
				// full ram as the default window
				chans[ch].start_address <= '0;
				chans[ch].end_address <= '1;
			end else begin
				// write only lands on the addressed channel
				chans[ch].write_enable <= is_write && hit;
				// sync goes everywhere, channel field ignored
				chans[ch].sync <= is_sync;
				// new window waits here until the channel wraps or syncs
				if (is_bounds && hit) begin
					chans[ch].start_address <= cmd.payload.bounds.start_address;
					chans[ch].end_address <= cmd.payload.bounds.end_address;
				end
			end
		end

		// write address and byte, only meaningful with the strobe
		always_ff @(posedge clock) begin
			if (is_write && hit) begin
				chans[ch].write_address <= cmd.payload.write.address;
				chans[ch].write_data <= cmd.payload.write.data;
			end
		end
	end

	// lane enable mask, channel field ignored
	always_ff @(posedge clock) begin
		if (rst) begin
			enables <= '0;
		end else if (is_enable) begin
			enables <= cmd.payload.enable.mask;
		end
	end

endmodule

// ==== hw/lane_combiner.sv ====
module lane_combiner import fg_pkg::*; (
	input logic clock,
	input logic rst,
	input data_t chan_data [num_channels],
	input logic [num_channels-1:0] chan_wrapped,
	input logic [num_channels-1:0] enables,
	output lanes_t data_out,
	output logic frame_start
);

	// mask staged once next to the lane flops
	logic [num_channels-1:0] mask_q;
	// lanes after gating, before the output register
	lanes_t gated;

	// disabled lanes forced to zero
	always_comb begin
		for (int lane = 0; lane < num_channels; lane++) begin
			gated[lane] = mask_q[lane] ? chan_data[lane] : '0;
		end
	end

	// mask lands two edges after the decoder samples it
	always_ff @(posedge clock) begin
		if (rst) begin
			mask_q <= '0;
		end else begin
			mask_q <= enables;
		end
	end

	// output word and frame marker leave together
	always_ff @(posedge clock) begin
		if (rst) begin
			data_out <= '0;
			frame_start <= 1'b0;
		end else begin
			data_out <= gated;
			// channel 0 paces the frame, mask does not apply
			frame_start <= chan_wrapped[0];
		end
	end

endmodule

// ==== hw/pattern_generator.sv ====
module pattern_generator import fg_pkg::*; (
	input logic clock,
	input logic rst,
	input logic cmd_valid,
	input cmd_word_t cmd,
	output lanes_t data_out,
	output logic frame_start
);

	// one config path per channel
	pattern_if chan_cfg [num_channels] ();

	// ram bytes from each channel
	data_t chan_data [num_channels];
	// start-of-pass flags, aligned with chan_data
	logic [num_channels-1:0] chan_wrapped;
	// lane enable mask from the decoder
	logic [num_channels-1:0] enables;

	// host commands into per-channel writes, windows, sync and mask
	command_decoder u_decoder (
		.clock(clock),
		.rst(rst),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.chans(chan_cfg),
		.enables(enables)
	);

	// channels run independently
	// they only share sync
	for (genvar ch = 0; ch < num_channels; ch++) begin : g_chan
		pattern_channel u_channel (
			.clock(clock),
			.rst(rst),
			.cfg(chan_cfg[ch]),
			.data(chan_data[ch]),
			.wrapped(chan_wrapped[ch])
		);
	end

	// gate, register and pack the lanes
	lane_combiner u_combiner (
		.clock(clock),
		.rst(rst),
		.chan_data(chan_data),
		.chan_wrapped(chan_wrapped),
		.enables(enables),
		.data_out(data_out),
		.frame_start(frame_start)
	);

endmodule

// ==== pattern_channel/pattern_channel.sv ====
module pattern_channel import fg_pkg::*; (
	input logic clock,
	input logic rst,
	pattern_if.channel cfg,
	output data_t data,
	output logic wrapped
);

	// address sent to the ram this cycle
	addr_t read_address;
	// window the current pass runs in
	addr_t active_start;
	addr_t active_end;
	// set by the first wrap or sync after reset
	logic running;
	// restart from start on the next edge
	logic reload;
	// read address sits on the start of a fresh pass
	logic at_start;

	// sync wins, otherwise wrap after the inclusive end
	assign reload = cfg.sync || (read_address == active_end);

	// read sequencer
	always_ff @(posedge clock) begin
		if (rst) begin
			read_address <= '0;
			active_start <= '0;
			active_end <= '1;
			running <= 1'b0;
		end else if (reload) begin
			// the programmed window becomes active only here
			read_address <= cfg.start_address;
			active_start <= cfg.start_address;
			active_end <= cfg.end_address;
			running <= 1'b1;
		end else begin
			read_address <= read_address + addr_t'(1);
		end
	end

	// the address only returns to start through a reload
	// so this marks the first byte of every pass
	assign at_start = running && (read_address == active_start);

	// delayed one cycle to line up with ram data
	always_ff @(posedge clock) begin
		if (rst) begin
			wrapped <= 1'b0;
		end else begin
			wrapped <= at_start;
		end
	end

	// pattern store, host writes come straight from the decoder
	pattern_ram u_ram (
		.clock(clock),
		.write_enable(cfg.write_enable),
		.write_address(cfg.write_address),
		.write_data(cfg.write_data),
		.read_address(read_address),
		.read_data(data)
	);

endmodule

// ==== pattern_channel/pattern_ram.sv ====
// simple dual-port pattern store, one write port and one read port
module pattern_ram import fg_pkg::*; (
	input logic clock,
	input logic write_enable,
	input addr_t write_address,
	input data_t write_data,
	input addr_t read_address,
	output data_t read_data
);

	// contents undefined until the host loads them
	data_t mem [ram_depth];

	// host side write
	always_ff @(posedge clock) begin
		if (write_enable) begin
			mem[write_address] <= write_data;
		end
	end

	// registered read, one cycle of latency
	// same-address read and write returns the old byte
	always_ff @(posedge clock) begin
		read_data <= mem[read_address];
	end

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the pattern generator testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --assert --timescale 1ns/100ps \
	--top-module pattern_generator_tb -f flist.f -o pattern_generator_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/pattern_generator_sim +verilator+error+limit+1000 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Test OK" "$log"; then
	exit 0
fi
echo "pass message not found in $log"
exit 1
